// File: vlog.f
+incdir+rtl
rtl/engine_ctrl_pkg.sv
rtl/engine_data_pkg.sv
rtl/conv_channel.sv
rtl/burst_controller.sv
rtl/result_writeback.sv
rtl/engine.sv
verification/engine_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= engine_tb
FILELIST ?= vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\*\* PASSED \*\*\*'

clean:
	rm -rf obj_dir

// File: verification/engine_tb.sv
// Self-checking testbench for the convolution engine, run from the project root with vlog.f
`timescale 1ns/100ps
`include "engine_defines.svh"

module engine_tb;

	localparam int LANES = `ENGINE_LANES;
	localparam int NUM_ROWS = 10;

	typedef struct packed {
		logic [2:0] op;
		logic [15:0] num;
		logic use_ch0;
		logic use_ch1;
	} row_t;

	// Op code, terms per lane, then whether channel 0 and channel 1 read and write
	row_t rows [NUM_ROWS] = '{
		'{3'd1, 16'd3, 1'b1, 1'b0},
		'{3'd2, 16'd2, 1'b0, 1'b1},
		'{3'd3, 16'd5, 1'b1, 1'b1},
		'{3'd3, 16'd1, 1'b1, 1'b1},
		'{3'd1, 16'd0, 1'b1, 1'b0},
		'{3'd0, 16'd3, 1'b0, 1'b0},
		'{3'd4, 16'd2, 1'b0, 1'b0},
		'{3'd7, 16'd1, 1'b0, 1'b0},
		'{3'd3, 16'd0, 1'b1, 1'b1},
		'{3'd2, 16'd40, 1'b0, 1'b1}
	};

	logic clk = 1'b0;
	logic rst;
	logic conv_ready;
	engine_ctrl_pkg::op_t op_type;
	logic [`ENGINE_OP_NUM_W-1:0] op_num;
	engine_data_pkg::conv_pair_t ch0_pair;
	engine_data_pkg::conv_pair_t ch1_pair;
	logic ch0_rd_en;
	logic ch1_rd_en;
	engine_data_pkg::result_port_t p0_out;
	engine_data_pkg::result_port_t p1_out;
	logic conv_valid;

	engine_data_pkg::conv_pair_t fifo0 [$];
	engine_data_pkg::conv_pair_t fifo1 [$];
	engine_data_pkg::sample_t exp0 [LANES];
	engine_data_pkg::sample_t exp1 [LANES];
	logic pend0;
	logic pend1;
	logic prev_valid;
	int rd0;
	int rd1;
	int wr0;
	int wr1;
	int exp_wr0;
	int exp_wr1;
	int errors = 0;
	int checks = 0;

	always #5 clk = ~clk;

	engine engine_inst (
		.clk(clk),
		.rst(rst),
		.conv_ready(conv_ready),
		.op_type(op_type),
		.op_num(op_num),
		.ch0_pair(ch0_pair),
		.ch1_pair(ch1_pair),
		.ch0_rd_en(ch0_rd_en),
		.ch1_rd_en(ch1_rd_en),
		.p0_out(p0_out),
		.p1_out(p1_out),
		.conv_valid(conv_valid)
	);

	function automatic engine_data_pkg::sample_t product_lo(input engine_data_pkg::conv_pair_t w);
		logic [31:0] p;
		p = 32'(w.data) * 32'(w.weight);
		return p[15:0];
	endfunction

	task automatic compare_count(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_write(input string name, input int idx,
		input engine_data_pkg::sample_t expected, input engine_data_pkg::sample_t actual);
		checks++;
		if (idx >= LANES || prev_valid) begin
			errors++;
			$display("Error at %0t: %s written after the last lane or while conv_valid was high",
				$time, name);
		end else if (expected != actual) begin
			errors++;
			$display("Mismatch at %0t: %s lane %0d expected %h actual %h",
				$time, name, idx, expected, actual);
		end
	endtask

	task automatic check_idle();
		compare_bit("ch0_rd_en", 1'b0, ch0_rd_en);
		compare_bit("ch1_rd_en", 1'b0, ch1_rd_en);
		compare_bit("p0_out.wr_en", 1'b0, p0_out.wr_en);
		compare_bit("p1_out.wr_en", 1'b0, p1_out.wr_en);
		compare_bit("conv_valid", 1'b0, conv_valid);
	endtask

	// FIFO models: a word appears in the cycle after its read strobe
	always @(negedge clk) begin
		if (pend0 && fifo0.size() > 0) begin
			ch0_pair = fifo0.pop_front();
		end
		if (pend1 && fifo1.size() > 0) begin
			ch1_pair = fifo1.pop_front();
		end
		pend0 = ch0_rd_en;
		pend1 = ch1_rd_en;
	end

	// Counts reads and writes and checks each result word as it is written
	always @(negedge clk) begin
		if (ch0_rd_en) begin
			rd0++;
		end
		if (ch1_rd_en) begin
			rd1++;
		end
		if (p0_out.wr_en) begin
			check_write("p0_out.data", wr0, exp0[`ENGINE_LANE_W'(wr0)], p0_out.data);
			wr0++;
		end
		if (p1_out.wr_en) begin
			check_write("p1_out.data", wr1, exp1[`ENGINE_LANE_W'(wr1)], p1_out.data);
			wr1++;
		end
		// Dual operation writes both ports in the same cycles
		if (exp_wr0 != 0 && exp_wr1 != 0 && (p0_out.wr_en || p1_out.wr_en)) begin
			compare_bit("p1_out.wr_en", p0_out.wr_en, p1_out.wr_en);
		end
		if (conv_valid && !prev_valid && (wr0 != exp_wr0 || wr1 != exp_wr1)) begin
			errors++;
			$display("Error at %0t: conv_valid rose before all result words were written", $time);
		end
		prev_valid = conv_valid;
	end

	task automatic run_row(input row_t row);
		engine_data_pkg::conv_pair_t word;
		logic [`ENGINE_LANE_W-1:0] lane;
		int n_words;
		int limit;
		int cycles;
		n_words = int'(row.num) * LANES;
		limit = n_words + LANES + 20;
		fifo0.delete();
		fifo1.delete();
		foreach (exp0[i]) begin
			exp0[i] = '0;
			exp1[i] = '0;
		end
		for (int k = 0; k < n_words; k++) begin
			lane = `ENGINE_LANE_W'(k % LANES);
			if (row.use_ch0) begin
				word = engine_data_pkg::conv_pair_t'($urandom);
				fifo0.push_back(word);
				exp0[lane] = exp0[lane] + product_lo(word);
			end
			if (row.use_ch1) begin
				word = engine_data_pkg::conv_pair_t'($urandom);
				fifo1.push_back(word);
				exp1[lane] = exp1[lane] + product_lo(word);
			end
		end
		@(negedge clk);
		rd0 = 0;
		rd1 = 0;
		wr0 = 0;
		wr1 = 0;
		exp_wr0 = row.use_ch0 ? LANES : 0;
		exp_wr1 = row.use_ch1 ? LANES : 0;
		op_type = engine_ctrl_pkg::op_t'(row.op);
		op_num = row.num;
		conv_ready = 1'b1;
		cycles = 0;
		if (row.use_ch0 || row.use_ch1) begin
			while (!conv_valid && cycles < limit) begin
				@(negedge clk);
				cycles++;
			end
			if (!conv_valid) begin
				errors++;
				$display("Error at %0t: conv_valid did not rise within %0d cycles", $time, limit);
			end
			compare_count("ch0_rd_en cycles", row.use_ch0 ? n_words : 0, rd0);
			compare_count("ch1_rd_en cycles", row.use_ch1 ? n_words : 0, rd1);
			compare_count("p0_out.wr_en cycles", exp_wr0, wr0);
			compare_count("p1_out.wr_en cycles", exp_wr1, wr1);
		end else begin
			repeat (limit) @(negedge clk);
			checks++;
			if (rd0 != 0 || rd1 != 0 || wr0 != 0 || wr1 != 0 || conv_valid) begin
				errors++;
				$display("Error at %0t: invalid op %0d caused reads, writes or conv_valid",
					$time, row.op);
			end
		end
		conv_ready = 1'b0;
		cycles = 0;
		while (conv_valid && cycles < 4) begin
			@(negedge clk);
			cycles++;
		end
		if (conv_valid) begin
			errors++;
			$display("Error at %0t: conv_valid stayed high after conv_ready dropped", $time);
		end
	endtask

	initial begin
		int unsigned seed_dummy;
		int row_err;
		seed_dummy = $urandom(32'hcb6c6d72);
		rst = 1'b1;
		conv_ready = 1'b0;
		op_type = engine_ctrl_pkg::op_t'(3'd0);
		op_num = '0;
		ch0_pair = '0;
		ch1_pair = '0;
		pend0 = 1'b0;
		pend1 = 1'b0;
		prev_valid = 1'b0;
		exp_wr0 = 0;
		exp_wr1 = 0;
		repeat (10) begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_err = errors;
			run_row(rows[r]);
			$display("Row %0d op %0d op_num %0d: %s", r, rows[r].op, rows[r].num,
				(errors == row_err) ? "ok" : "errors found");
		end
		$display("Rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Twice the summed row budgets, in ns
	initial begin
		int limit_ns;
		limit_ns = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit_ns = limit_ns + (int'(rows[r].num) * LANES + LANES + 20) * 10;
		end
		#(2 * limit_ns);
		$display("Watchdog expired at %0t: the run did not finish in time", $time);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: rtl/engine.sv
// Convolution engine top: burst controller, two MAC lane channels and the result writeback
`timescale 1ns/100ps
`include "engine_defines.svh"

module engine (
	input logic clk,
	input logic rst,
	input logic conv_ready,
	input engine_ctrl_pkg::op_t op_type,
	input logic [`ENGINE_OP_NUM_W-1:0] op_num,
	input engine_data_pkg::conv_pair_t ch0_pair,
	input engine_data_pkg::conv_pair_t ch1_pair,
	output logic ch0_rd_en,
	output logic ch1_rd_en,
	output engine_data_pkg::result_port_t p0_out,
	output engine_data_pkg::result_port_t p1_out,
	output logic conv_valid
);

	engine_ctrl_pkg::lane_strobe_t ch0_strobe;
	engine_ctrl_pkg::lane_strobe_t ch1_strobe;
	engine_ctrl_pkg::port_mask_t wb_mask;
	logic clear;
	logic wb_start;
	logic wb_done;
	logic [`ENGINE_LANE_W-1:0] wb_lane;
	engine_data_pkg::sample_t ch0_result;
	engine_data_pkg::sample_t ch1_result;

	burst_controller burst_controller_inst (
		.clk(clk),
		.rst(rst),
		.conv_ready(conv_ready),
		.op_type(op_type),
		.op_num(op_num),
		.ch0_rd_en(ch0_rd_en),
		.ch1_rd_en(ch1_rd_en),
		.ch0_strobe(ch0_strobe),
		.ch1_strobe(ch1_strobe),
		.clear(clear),
		.wb_start(wb_start),
		.wb_mask(wb_mask),
		.wb_done(wb_done),
		.conv_valid(conv_valid)
	);

	conv_channel conv_channel_0 (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.strobe(ch0_strobe),
		.pair(ch0_pair),
		.wb_lane(wb_lane),
		.lane_result(ch0_result)
	);

	conv_channel conv_channel_1 (
		.clk(clk),
		.rst(rst),
		.clear(clear),
		.strobe(ch1_strobe),
		.pair(ch1_pair),
		.wb_lane(wb_lane),
		.lane_result(ch1_result)
	);

	result_writeback result_writeback_inst (
		.clk(clk),
		.rst(rst),
		.wb_start(wb_start),
		.wb_mask(wb_mask),
		.ch0_result(ch0_result),
		.ch1_result(ch1_result),
		.wb_lane(wb_lane),
		.p0_out(p0_out),
		.p1_out(p1_out),
		.wb_done(wb_done)
	);

endmodule

// File: rtl/result_writeback.sv
// Streams the channel lane results, lane 0 first, onto the masked result FIFO ports
`timescale 1ns/100ps
`include "engine_defines.svh"

module result_writeback (
	input logic clk,
	input logic rst,
	input logic wb_start,
	input engine_ctrl_pkg::port_mask_t wb_mask,
	input engine_data_pkg::sample_t ch0_result,
	input engine_data_pkg::sample_t ch1_result,
	output logic [`ENGINE_LANE_W-1:0] wb_lane,
	output engine_data_pkg::result_port_t p0_out,
	output engine_data_pkg::result_port_t p1_out,
	output logic wb_done
);

	logic active;
	logic writing;
	logic last_wr;

	// Lane 0 is already selected while wb_start is high
	assign writing = wb_start || active;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			wb_lane <= '0;
			last_wr <= 1'b0;
			wb_done <= 1'b0;
			p0_out <= '0;
			p1_out <= '0;
		end else begin
			last_wr <= writing && (wb_lane == `ENGINE_LANE_W'(`ENGINE_LANES - 1));
			wb_done <= last_wr;
			if (writing) begin
				p0_out <= wb_mask.p0 ? '{wr_en: 1'b1, data: ch0_result} : '0;
				p1_out <= wb_mask.p1 ? '{wr_en: 1'b1, data: ch1_result} : '0;
				if (wb_lane == `ENGINE_LANE_W'(`ENGINE_LANES - 1)) begin
					active <= 1'b0;
					wb_lane <= '0;
				end else begin
					active <= 1'b1;
					wb_lane <= wb_lane + 1'b1;
				end
			end else begin
				p0_out <= '0;
				p1_out <= '0;
			end
		end
	end

endmodule

// File: rtl/burst_controller.sv
// Operation FSM for the engine: decodes the op, strobes FIFO reads lane by lane and starts writeback
`timescale 1ns/100ps
`include "engine_defines.svh"

module burst_controller (
	input logic clk,
	input logic rst,
	input logic conv_ready,
	input engine_ctrl_pkg::op_t op_type,
	input logic [`ENGINE_OP_NUM_W-1:0] op_num,
	output logic ch0_rd_en,
	output logic ch1_rd_en,
	output engine_ctrl_pkg::lane_strobe_t ch0_strobe,
	output engine_ctrl_pkg::lane_strobe_t ch1_strobe,
	output logic clear,
	output logic wb_start,
	output engine_ctrl_pkg::port_mask_t wb_mask,
	input logic wb_done,
	output logic conv_valid
);

	localparam int CNT_W = `ENGINE_OP_NUM_W + `ENGINE_LANE_W;
	// FIFO latency plus the two channel pipeline stages
	localparam int DRAIN_CYCLES = 3;

	engine_ctrl_pkg::state_t state;
	engine_ctrl_pkg::port_mask_t op_mask;
	engine_ctrl_pkg::port_mask_t start_mask;
	logic start;
	logic [CNT_W-1:0] rd_total;
	logic [CNT_W-1:0] rd_cnt;
	logic [`ENGINE_LANE_W-1:0] rd_lane;
	logic [1:0] drain_cnt;

	// Channel enables double as the result port mask
	always_comb begin
		start_mask = '0;
		case (op_type)
			engine_ctrl_pkg::OP_CH0: start_mask.p0 = 1'b1;
			engine_ctrl_pkg::OP_CH1: start_mask.p1 = 1'b1;
			engine_ctrl_pkg::OP_DUAL: start_mask = '{p0: 1'b1, p1: 1'b1};
			default: start_mask = '0;
		endcase
	end

	assign start = (state == engine_ctrl_pkg::ST_IDLE) && conv_ready &&
		(start_mask.p0 || start_mask.p1);

	assign ch0_rd_en = (state == engine_ctrl_pkg::ST_READING) && op_mask.p0;
	assign ch1_rd_en = (state == engine_ctrl_pkg::ST_READING) && op_mask.p1;
	assign wb_mask = op_mask;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= engine_ctrl_pkg::ST_IDLE;
			op_mask <= '0;
			rd_total <= '0;
			rd_cnt <= '0;
			rd_lane <= '0;
			drain_cnt <= '0;
			ch0_strobe <= '0;
			ch1_strobe <= '0;
			clear <= 1'b0;
			wb_start <= 1'b0;
			conv_valid <= 1'b0;
		end else begin
			// FIFO word shows up one cycle after its read strobe
			ch0_strobe <= '{valid: ch0_rd_en, lane: rd_lane};
			ch1_strobe <= '{valid: ch1_rd_en, lane: rd_lane};
			clear <= start || !conv_ready;
			wb_start <= 1'b0;
			case (state)
				engine_ctrl_pkg::ST_IDLE: begin
					if (start) begin
						op_mask <= start_mask;
						rd_total <= CNT_W'(op_num * `ENGINE_LANES);
						rd_cnt <= '0;
						rd_lane <= '0;
						drain_cnt <= '0;
						state <= (op_num == '0) ? engine_ctrl_pkg::ST_DRAINING :
							engine_ctrl_pkg::ST_READING;
					end
				end
				engine_ctrl_pkg::ST_READING: begin
					rd_cnt <= rd_cnt + 1'b1;
					rd_lane <= (rd_lane == `ENGINE_LANE_W'(`ENGINE_LANES - 1)) ? '0 :
						rd_lane + 1'b1;
					if (rd_cnt == rd_total - 1'b1) begin
						state <= engine_ctrl_pkg::ST_DRAINING;
					end
				end
				engine_ctrl_pkg::ST_DRAINING: begin
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
						state <= engine_ctrl_pkg::ST_WRITING;
						wb_start <= 1'b1;
					end
				end
				engine_ctrl_pkg::ST_WRITING: begin
					if (wb_done) begin
						state <= engine_ctrl_pkg::ST_FINISHED;
						conv_valid <= 1'b1;
					end
				end
				engine_ctrl_pkg::ST_FINISHED: begin
					if (!conv_ready) begin
						state <= engine_ctrl_pkg::ST_IDLE;
						conv_valid <= 1'b0;
					end
				end
				default: state <= engine_ctrl_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/conv_channel.sv
// One convolution channel: a bank of MAC lanes fed by a two-stage multiply/accumulate pipeline
`timescale 1ns/100ps
`include "engine_defines.svh"

module conv_channel (
	input logic clk,
	input logic rst,
	input logic clear,
	input engine_ctrl_pkg::lane_strobe_t strobe,
	input engine_data_pkg::conv_pair_t pair,
	input logic [`ENGINE_LANE_W-1:0] wb_lane,
	output engine_data_pkg::sample_t lane_result
);

	engine_data_pkg::acc_t acc [`ENGINE_LANES];
	engine_data_pkg::acc_t prod;
	engine_ctrl_pkg::lane_strobe_t prod_tag;

	// Lane tag follows the product into the accumulate stage
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_tag <= '0;
		end else if (clear) begin
			prod_tag <= '0;
		end else begin
			prod_tag <= strobe;
		end
	end

	// Multiply stage, full 32-bit product of unsigned operands
	always_ff @(posedge clk) begin
		if (strobe.valid) begin
			prod <= engine_data_pkg::acc_t'(pair.data) *
				engine_data_pkg::acc_t'(pair.weight);
		end
	end

	// Accumulate stage
	always_ff @(posedge clk) begin
		if (clear) begin
			for (int i = 0; i < `ENGINE_LANES; i++) begin
				acc[i] <= '0;
			end
		end else if (prod_tag.valid) begin
			acc[prod_tag.lane] <= acc[prod_tag.lane] + prod;
		end
	end

	// Result wraps modulo 2^16
	assign lane_result = acc[wb_lane][`ENGINE_SAMPLE_W-1:0];

endmodule

// File: rtl/engine_data_pkg.sv
// Datapath word types for FIFO pairs, lane accumulators and result FIFO write ports
`include "engine_defines.svh"

package engine_data_pkg;

	typedef logic [`ENGINE_SAMPLE_W-1:0] sample_t;

	typedef logic [`ENGINE_ACC_W-1:0] acc_t;

	// One read word from a channel's data and weight FIFOs
	typedef struct packed {
		sample_t data;
		sample_t weight;
	} conv_pair_t;

	// One result FIFO write port
	typedef struct packed {
		logic wr_en;
		sample_t data;
	} result_port_t;

endpackage

// File: rtl/engine_ctrl_pkg.sv
// Control-path types shared by the burst controller, result writeback and engine top
`include "engine_defines.svh"

package engine_ctrl_pkg;

	typedef enum logic [2:0] {
		OP_CH0 = `ENGINE_OP_CH0,
		OP_CH1 = `ENGINE_OP_CH1,
		OP_DUAL = `ENGINE_OP_DUAL
	} op_t;

	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_READING = 3'd1,
		ST_DRAINING = 3'd2,
		ST_WRITING = 3'd3,
		ST_FINISHED = 3'd4
	} state_t;

	// Marks the cycle a channel's FIFO pair is valid, and its lane
	typedef struct packed {
		logic valid;
		logic [`ENGINE_LANE_W-1:0] lane;
	} lane_strobe_t;

	typedef struct packed {
		logic p0;
		logic p1;
	} port_mask_t;

endpackage

// File: rtl/engine_defines.svh
// Engine-wide sizing and op code macros, included by the packages and every RTL module
`ifndef ENGINE_DEFINES_SVH
`define ENGINE_DEFINES_SVH

// MAC lanes per convolution channel, and the width of a lane index
`define ENGINE_LANES 4
`define ENGINE_LANE_W 2

// Data, weight and result word width
`define ENGINE_SAMPLE_W 16

// Terms summed per lane
`define ENGINE_OP_NUM_W 16

// Lane accumulator width
`define ENGINE_ACC_W 32

// Convolution op codes on op_type
`define ENGINE_OP_CH0 3'd1
`define ENGINE_OP_CH1 3'd2
`define ENGINE_OP_DUAL 3'd3

`endif
